/* spi_arb_pkg.sv */
// ****************************************
// spi arbiter arbitration types
// requester ids, control states and the
// per-requester vector type
// ****************************************
`default_nettype none

package spi_arb_pkg;

	localparam int NUM_REQ = 4;

	// channel slots in the request vectors
	localparam int CH_MCU_RD   = 0;
	localparam int CH_MCU_WR   = 1;
	localparam int CH_FPGA_RD0 = 2;
	localparam int CH_FPGA_RD1 = 3;

	// order doubles as tie-break order, id is channel slot + 1
	typedef enum logic [2:0] {
		REQ_NONE,
		REQ_MCU_RD,
		REQ_MCU_WR,
		REQ_FPGA_RD0,
		REQ_FPGA_RD1
	} req_id_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LAUNCH,
		ST_WAIT_DONE
	} arb_state_e;

	typedef logic [NUM_REQ-1:0] req_vec_t;	// one bit per requester

endpackage

`default_nettype wire

/* spi_bus_pkg.sv */
// ****************************************
// spi driver side definitions
// field widths, status register location
// and the command structs
// ****************************************
`default_nettype none

package spi_bus_pkg;

	localparam int ADDR_W = 10;
	localparam int DATA_W = 8;
	localparam int MOD_W  = 3;
	localparam int CHIP_W = 2;

	localparam logic [ADDR_W-1:0] STATUS_ADDR = 10'h10C;	// polled by the fpga readers
	localparam logic [CHIP_W-1:0] FPGA0_CHIP  = 2'd0;
	localparam logic [CHIP_W-1:0] FPGA1_CHIP  = 2'd1;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [MOD_W-1:0]  mod_sel;
		logic [DATA_W-1:0] wr_data;
		logic [CHIP_W-1:0] chip;
	} mcu_cmd_t;

	typedef struct packed {
		logic              rd;
		logic              wr;
		logic [ADDR_W-1:0] addr;
		logic [MOD_W-1:0]  mod_sel;
		logic [DATA_W-1:0] wr_data;
		logic [CHIP_W-1:0] chip;
	} spi_cmd_t;

endpackage

`default_nettype wire

/* req_tracker.sv */
// ****************************************
// request tracker
// syncs the request levels, catches rising
// edges, keeps pending flags and wait ages
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module req_tracker #(
	parameter int WAIT_W = 16
) (
	input  wire logic                                            i_clk,
	input  wire logic                                            i_rst_n,
	input  wire logic [spi_arb_pkg::NUM_REQ-1:0]                 i_req,
	input  wire logic                                            i_grant,
	input  spi_arb_pkg::req_id_e                                 i_grant_id,
	output spi_arb_pkg::req_vec_t                                o_pending,
	output logic [spi_arb_pkg::NUM_REQ-1:0][WAIT_W-1:0]          o_age
);

	import spi_arb_pkg::*;

	req_vec_t req_s0;
	req_vec_t req_s1;
	req_vec_t req_s2;	// previous sync output, for the edge
	req_vec_t req_edge;
	req_vec_t grant_hit;

	always_ff @(posedge i_clk)
	begin
		req_s0 <= i_req;
		req_s1 <= req_s0;
		req_s2 <= req_s1;
	end

	assign req_edge = req_s1 & ~req_s2;

	// decode the grant onto its channel
	always_comb
	begin
		for (int i = 0; i < NUM_REQ; i++)
		begin
			grant_hit[i] = i_grant && (i_grant_id == req_id_e'(i + 1));
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_pending <= '0;
			o_age     <= '0;
		end
		else
		begin
			for (int i = 0; i < NUM_REQ; i++)
			begin
				// a fresh edge beats a grant in the same cycle
				if (req_edge[i])
					o_pending[i] <= 1'b1;
				else if (grant_hit[i])
					o_pending[i] <= 1'b0;

				if (grant_hit[i] || !o_pending[i])
					o_age[i] <= '0;
				else if (o_age[i] != '1)
					o_age[i] <= o_age[i] + 1'b1;	// saturates
			end
		end
	end

endmodule

`default_nettype wire

/* age_compare.sv */
// ****************************************
// oldest-first comparator
// two registered stages, earlier id wins
// on equal age
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module age_compare #(
	parameter int WAIT_W = 16
) (
	input  wire logic                                       i_clk,
	input  wire logic                                       i_rst_n,
	input  spi_arb_pkg::req_vec_t                           i_pending,
	input  wire logic [spi_arb_pkg::NUM_REQ-1:0][WAIT_W-1:0] i_age,
	output spi_arb_pkg::req_id_e                            o_winner
);

	import spi_arb_pkg::*;

	req_id_e           mcu_id;
	req_id_e           fpga_id;
	logic [WAIT_W-1:0] mcu_age;
	logic [WAIT_W-1:0] fpga_age;

	// second candidate must be strictly older to take over
	function automatic logic second_wins(
		input logic              valid_a,
		input logic              valid_b,
		input logic [WAIT_W-1:0] age_a,
		input logic [WAIT_W-1:0] age_b
	);
		return valid_b && (!valid_a || (age_b > age_a));
	endfunction

	// stage 1 pairs up the mcu and the fpga channels
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			mcu_id   <= REQ_NONE;
			fpga_id  <= REQ_NONE;
			mcu_age  <= '0;
			fpga_age <= '0;
		end
		else
		begin
			if (second_wins(i_pending[CH_MCU_RD], i_pending[CH_MCU_WR],
			                i_age[CH_MCU_RD], i_age[CH_MCU_WR]))
			begin
				mcu_id  <= REQ_MCU_WR;
				mcu_age <= i_age[CH_MCU_WR];
			end
			else
			begin
				mcu_id  <= i_pending[CH_MCU_RD] ? REQ_MCU_RD : REQ_NONE;
				mcu_age <= i_age[CH_MCU_RD];
			end

			if (second_wins(i_pending[CH_FPGA_RD0], i_pending[CH_FPGA_RD1],
			                i_age[CH_FPGA_RD0], i_age[CH_FPGA_RD1]))
			begin
				fpga_id  <= REQ_FPGA_RD1;
				fpga_age <= i_age[CH_FPGA_RD1];
			end
			else
			begin
				fpga_id  <= i_pending[CH_FPGA_RD0] ? REQ_FPGA_RD0 : REQ_NONE;
				fpga_age <= i_age[CH_FPGA_RD0];
			end
		end
	end

	// stage 2 keeps the mcu side on ties
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
			o_winner <= REQ_NONE;
		else if (second_wins(mcu_id != REQ_NONE, fpga_id != REQ_NONE, mcu_age, fpga_age))
			o_winner <= fpga_id;
		else
			o_winner <= mcu_id;
	end

endmodule

`default_nettype wire

/* arb_fsm.sv */
// ****************************************
// arbiter control
// grants the winner, times the launch and
// watches the driver's done level
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module arb_fsm #(
	parameter int LAUNCH_DELAY = 6
) (
	input  wire logic           i_clk,
	input  wire logic           i_rst_n,
	input  spi_arb_pkg::req_id_e i_winner,
	input  wire logic           i_spi_done,
	output logic                o_grant,
	output spi_arb_pkg::req_id_e o_owner,
	output logic                o_launch,
	output logic                o_done
);

	import spi_arb_pkg::*;

	localparam int CNT_W = $clog2(LAUNCH_DELAY + 1);

	arb_state_e       state;
	logic [CNT_W-1:0] delay_cnt;
	logic             done_s0;
	logic             done_s1;
	logic             done_s2;

	// done comes from another block, sync before use
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			done_s0 <= 1'b0;
			done_s1 <= 1'b0;
			done_s2 <= 1'b0;
		end
		else
		begin
			done_s0 <= i_spi_done;
			done_s1 <= done_s0;
			done_s2 <= done_s1;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state     <= ST_IDLE;
			delay_cnt <= '0;
			o_grant   <= 1'b0;
			o_owner   <= REQ_NONE;
			o_launch  <= 1'b0;
			o_done    <= 1'b0;
		end
		else
		begin
			o_grant  <= 1'b0;
			o_launch <= 1'b0;
			o_done   <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					if (i_winner != REQ_NONE)
					begin
						o_grant   <= 1'b1;
						o_owner   <= i_winner;	// held until next grant
						delay_cnt <= CNT_W'(1);
						state     <= ST_LAUNCH;
					end
				end
				ST_LAUNCH:
				begin
					// strobe lands LAUNCH_DELAY cycles after the grant
					if (delay_cnt == CNT_W'(LAUNCH_DELAY - 1))
					begin
						o_launch <= 1'b1;
						state    <= ST_WAIT_DONE;
					end
					else
						delay_cnt <= delay_cnt + 1'b1;
				end
				ST_WAIT_DONE:
				begin
					if (done_s1 && !done_s2)
					begin
						o_done <= 1'b1;
						state  <= ST_IDLE;
					end
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* spi_cmd_mux.sv */
// ****************************************
// spi command register
// builds the driver command for the owner
// and issues the rd or wr strobe
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_mux (
	input  wire logic             i_clk,
	input  wire logic             i_rst_n,
	input  wire logic             i_grant,
	input  spi_arb_pkg::req_id_e   i_owner,
	input  wire logic             i_launch,
	input  spi_bus_pkg::mcu_cmd_t  i_mcu_cmd,
	output spi_bus_pkg::spi_cmd_t  o_spi_cmd
);

	import spi_arb_pkg::*;
	import spi_bus_pkg::*;

	mcu_cmd_t fields_q;
	logic     rd_q;
	logic     wr_q;

	// fields load on grant, stay put through the transfer
	always_ff @(posedge i_clk)
	begin
		if (i_grant)
		begin
			case (i_owner)
				REQ_MCU_RD, REQ_MCU_WR:
					fields_q <= i_mcu_cmd;
				REQ_FPGA_RD0:
					fields_q <= '{addr: STATUS_ADDR, mod_sel: '0, wr_data: '0, chip: FPGA0_CHIP};
				REQ_FPGA_RD1:
					fields_q <= '{addr: STATUS_ADDR, mod_sel: '0, wr_data: '0, chip: FPGA1_CHIP};
				default:
					fields_q <= '0;
			endcase
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			rd_q <= 1'b0;
			wr_q <= 1'b0;
		end
		else
		begin
			rd_q <= i_launch && (i_owner inside {REQ_MCU_RD, REQ_FPGA_RD0, REQ_FPGA_RD1});
			wr_q <= i_launch && (i_owner == REQ_MCU_WR);
		end
	end

	assign o_spi_cmd = '{
		rd:      rd_q,
		wr:      wr_q,
		addr:    fields_q.addr,
		mod_sel: fields_q.mod_sel,
		wr_data: fields_q.wr_data,
		chip:    fields_q.chip
	};

endmodule

`default_nettype wire

/* return_router.sv */
// ****************************************
// return router
// steers the returned byte and a success
// pulse to the transfer's owner
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module return_router (
	input  wire logic                            i_clk,
	input  wire logic                            i_rst_n,
	input  wire logic                            i_done,
	input  spi_arb_pkg::req_id_e                  i_owner,
	input  wire logic [spi_bus_pkg::DATA_W-1:0]  i_spi_rdata,
	output logic [spi_bus_pkg::DATA_W-1:0]       o_data_mcu,
	output logic [spi_bus_pkg::DATA_W-1:0]       o_data_fpga0,
	output logic [spi_bus_pkg::DATA_W-1:0]       o_data_fpga1,
	output logic                                 o_success_mcu,
	output logic                                 o_success_fpga0,
	output logic                                 o_success_fpga1
);

	import spi_arb_pkg::*;
	import spi_bus_pkg::*;

	logic [DATA_W-1:0] rdata_d1;
	logic [DATA_W-1:0] rdata_d2;

	// byte delayed to line up with the done sync chain
	always_ff @(posedge i_clk)
	begin
		rdata_d1 <= i_spi_rdata;
		rdata_d2 <= rdata_d1;
	end

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_data_mcu      <= '0;
			o_data_fpga0    <= '0;
			o_data_fpga1    <= '0;
			o_success_mcu   <= 1'b0;
			o_success_fpga0 <= 1'b0;
			o_success_fpga1 <= 1'b0;
		end
		else
		begin
			o_success_mcu   <= 1'b0;
			o_success_fpga0 <= 1'b0;
			o_success_fpga1 <= 1'b0;
			if (i_done)
			begin
				case (i_owner)
					REQ_MCU_RD, REQ_MCU_WR:	// writes echo the driver byte too
					begin
						o_data_mcu    <= rdata_d2;
						o_success_mcu <= 1'b1;
					end
					REQ_FPGA_RD0:
					begin
						o_data_fpga0    <= rdata_d2;
						o_success_fpga0 <= 1'b1;
					end
					REQ_FPGA_RD1:
					begin
						o_data_fpga1    <= rdata_d2;
						o_success_fpga1 <= 1'b1;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* spi_arbiter.sv */
// ****************************************
// spi configuration bus arbiter
// oldest-first sharing of one spi driver
// between the mcu and two fpga readers
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module spi_arbiter #(
	parameter int WAIT_W       = 16,
	parameter int LAUNCH_DELAY = 6
) (
	input  wire logic                            i_clk,
	input  wire logic                            i_rst_n,
	input  wire logic                            i_rd_en_mcu,
	input  wire logic                            i_wr_en_mcu,
	input  wire logic                            i_rd_en_fpga0,
	input  wire logic                            i_rd_en_fpga1,
	input  spi_bus_pkg::mcu_cmd_t                 i_mcu_cmd,
	input  wire logic                            i_spi_done,
	input  wire logic [spi_bus_pkg::DATA_W-1:0]  i_spi_rdata,
	output spi_bus_pkg::spi_cmd_t                 o_spi_cmd,
	output logic [spi_bus_pkg::DATA_W-1:0]       o_data_mcu,
	output logic [spi_bus_pkg::DATA_W-1:0]       o_data_fpga0,
	output logic [spi_bus_pkg::DATA_W-1:0]       o_data_fpga1,
	output logic                                 o_success_mcu,
	output logic                                 o_success_fpga0,
	output logic                                 o_success_fpga1
);

	import spi_arb_pkg::*;

	req_vec_t                       req_lvl;
	req_vec_t                       req_pending;
	logic [NUM_REQ-1:0][WAIT_W-1:0] req_age;
	req_id_e                        winner;
	req_id_e                        owner;
	logic                           grant;
	logic                           launch;
	logic                           done;

	assign req_lvl[CH_MCU_RD]   = i_rd_en_mcu;
	assign req_lvl[CH_MCU_WR]   = i_wr_en_mcu;
	assign req_lvl[CH_FPGA_RD0] = i_rd_en_fpga0;
	assign req_lvl[CH_FPGA_RD1] = i_rd_en_fpga1;

	req_tracker #(.WAIT_W(WAIT_W)) tracker_i (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_req      (req_lvl),
		.i_grant    (grant),
		.i_grant_id (owner),
		.o_pending  (req_pending),
		.o_age      (req_age)
	);

	age_compare #(.WAIT_W(WAIT_W)) compare_i (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_pending (req_pending),
		.i_age     (req_age),
		.o_winner  (winner)
	);

	arb_fsm #(.LAUNCH_DELAY(LAUNCH_DELAY)) fsm_i (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_winner   (winner),
		.i_spi_done (i_spi_done),
		.o_grant    (grant),
		.o_owner    (owner),
		.o_launch   (launch),
		.o_done     (done)
	);

	spi_cmd_mux cmd_mux_i (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_grant   (grant),
		.i_owner   (owner),
		.i_launch  (launch),
		.i_mcu_cmd (i_mcu_cmd),
		.o_spi_cmd (o_spi_cmd)
	);

	return_router router_i (
		.i_clk           (i_clk),
		.i_rst_n         (i_rst_n),
		.i_done          (done),
		.i_owner         (owner),
		.i_spi_rdata     (i_spi_rdata),
		.o_data_mcu      (o_data_mcu),
		.o_data_fpga0    (o_data_fpga0),
		.o_data_fpga1    (o_data_fpga1),
		.o_success_mcu   (o_success_mcu),
		.o_success_fpga0 (o_success_fpga0),
		.o_success_fpga1 (o_success_fpga1)
	);

endmodule

`default_nettype wire

/* spi_arbiter_assert.sv */
// ****************************************
// spi arbiter port assertions
// strobe shape, one transfer at a time and
// success timing after the driver's done
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module spi_arbiter_assert (
	input  wire logic            i_clk,
	input  wire logic            i_rst_n,
	input  wire logic            i_spi_done,
	input  spi_bus_pkg::spi_cmd_t i_spi_cmd,
	input  wire logic            i_success_mcu,
	input  wire logic            i_success_fpga0,
	input  wire logic            i_success_fpga1
);

	int   fail_cnt = 0;
	logic strobe;
	logic any_success;
	logic xfer_open;	// strobe sent, success not yet seen

	assign strobe      = i_spi_cmd.rd || i_spi_cmd.wr;
	assign any_success = i_success_mcu || i_success_fpga0 || i_success_fpga1;

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
			xfer_open <= 1'b0;
		else if (strobe)
			xfer_open <= 1'b1;
		else if (any_success)
			xfer_open <= 1'b0;
	end

	rd_wr_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_spi_cmd.rd && i_spi_cmd.wr))
	else
	begin
		$error("rd and wr strobes high together");
		fail_cnt++;
	end

	rd_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_spi_cmd.rd |=> !i_spi_cmd.rd)
	else
	begin
		$error("rd strobe longer than one cycle");
		fail_cnt++;
	end

	wr_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_spi_cmd.wr |=> !i_spi_cmd.wr)
	else
	begin
		$error("wr strobe longer than one cycle");
		fail_cnt++;
	end

	success_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$onehot0({i_success_mcu, i_success_fpga0, i_success_fpga1}))
	else
	begin
		$error("more than one success pulse high");
		fail_cnt++;
	end

	no_overlap: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		strobe |-> !xfer_open)
	else
	begin
		$error("second strobe before the success of the first");
		fail_cnt++;
	end

	// two sync stages, edge detect, router register
	success_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$rose(i_spi_done) |-> ##4 any_success)
	else
	begin
		$error("no success 4 cycles after the done edge");
		fail_cnt++;
	end

endmodule

bind spi_arbiter spi_arbiter_assert assert_i (
	.i_clk           (i_clk),
	.i_rst_n         (i_rst_n),
	.i_spi_done      (i_spi_done),
	.i_spi_cmd       (o_spi_cmd),
	.i_success_mcu   (o_success_mcu),
	.i_success_fpga0 (o_success_fpga0),
	.i_success_fpga1 (o_success_fpga1)
);

`default_nettype wire

/* tb_spi_arbiter.sv */
// ****************************************
// spi arbiter testbench
// drives the request channels, models the
// spi driver and checks every transfer
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module tb_spi_arbiter;

	import spi_arb_pkg::*;
	import spi_bus_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int N_TRANS    = 14;	// transfers over all tests
	localparam int IDLE_TAIL  = 20;	// quiet cycles that expose extra strobes

	logic              clk;
	logic              rst_n;
	logic              rd_en_mcu;
	logic              wr_en_mcu;
	logic              rd_en_fpga0;
	logic              rd_en_fpga1;
	mcu_cmd_t          mcu_cmd;
	logic              spi_done;
	logic [DATA_W-1:0] spi_rdata;
	spi_cmd_t          spi_cmd;
	logic [DATA_W-1:0] data_mcu;
	logic [DATA_W-1:0] data_fpga0;
	logic [DATA_W-1:0] data_fpga1;
	logic              success_mcu;
	logic              success_fpga0;
	logic              success_fpga1;

	integer            seed = 32'h4a2a6b0b;
	int                errors;
	int                checks;
	int                tests;
	int                test_err_base;
	string             test_name;
	mcu_cmd_t          cur_cmd;
	logic [DATA_W-1:0] model_data [3];
	string             data_name [3] = '{"o_data_mcu", "o_data_fpga0", "o_data_fpga1"};

	req_id_e           exp_id_q [$];
	spi_cmd_t          exp_cmd_q [$];
	spi_cmd_t          served_cmd_q [$];
	logic [DATA_W-1:0] served_byte_q [$];
	int                succ_port_q [$];
	logic [DATA_W-1:0] succ_data_q [$];

	spi_arbiter dut_i (
		.i_clk           (clk),
		.i_rst_n         (rst_n),
		.i_rd_en_mcu     (rd_en_mcu),
		.i_wr_en_mcu     (wr_en_mcu),
		.i_rd_en_fpga0   (rd_en_fpga0),
		.i_rd_en_fpga1   (rd_en_fpga1),
		.i_mcu_cmd       (mcu_cmd),
		.i_spi_done      (spi_done),
		.i_spi_rdata     (spi_rdata),
		.o_spi_cmd       (spi_cmd),
		.o_data_mcu      (data_mcu),
		.o_data_fpga0    (data_fpga0),
		.o_data_fpga1    (data_fpga1),
		.o_success_mcu   (success_mcu),
		.o_success_fpga0 (success_fpga0),
		.o_success_fpga1 (success_fpga1)
	);

	function automatic int total_errors();
		return errors + dut_i.assert_i.fail_cnt;
	endfunction

	// command the driver should see for a requester
	function automatic spi_cmd_t expected_cmd(input req_id_e id, input mcu_cmd_t c);
		spi_cmd_t e;
		e    = '0;
		e.rd = (id != REQ_MCU_WR);
		e.wr = (id == REQ_MCU_WR);
		if (id == REQ_MCU_RD || id == REQ_MCU_WR)
		begin
			e.addr    = c.addr;
			e.mod_sel = c.mod_sel;
			e.wr_data = c.wr_data;
			e.chip    = c.chip;
		end
		else
		begin
			e.addr = STATUS_ADDR;
			e.chip = (id == REQ_FPGA_RD1) ? 2'd1 : 2'd0;
		end
		return e;
	endfunction

	function automatic int expected_port(input req_id_e id);
		if (id == REQ_FPGA_RD0)
			return 1;
		else if (id == REQ_FPGA_RD1)
			return 2;
		return 0;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		assert (got === exp)
		else
		begin
			$display("** Error @%0t ns: %s expected %0h, got %0h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name     = name;
		test_err_base = total_errors();
	endtask

	task automatic end_test();
		int n;
		n = total_errors() - test_err_base;
		tests++;
		$display("test %0d %s: %s (%0d errors)", tests, test_name, (n == 0) ? "ok" : "FAILED", n);
	endtask

	task automatic set_req(input req_id_e id, input logic val);
		case (id)
			REQ_MCU_RD:   rd_en_mcu   <= val;
			REQ_MCU_WR:   wr_en_mcu   <= val;
			REQ_FPGA_RD0: rd_en_fpga0 <= val;
			REQ_FPGA_RD1: rd_en_fpga1 <= val;
			default:      rd_en_mcu   <= rd_en_mcu;
		endcase
	endtask

	task automatic raise_req(input req_id_e id);
		exp_id_q.push_back(id);
		exp_cmd_q.push_back(expected_cmd(id, cur_cmd));
		set_req(id, 1'b1);
	endtask

	// lower every level and let the syncs settle
	task automatic drop_reqs();
		@(posedge clk);
		rd_en_mcu   <= 1'b0;
		wr_en_mcu   <= 1'b0;
		rd_en_fpga0 <= 1'b0;
		rd_en_fpga1 <= 1'b0;
		repeat (4) @(posedge clk);
	endtask

	task automatic new_cmd();
		logic [31:0] r;
		@(posedge clk);
		r       = $random(seed);
		cur_cmd = r[$bits(mcu_cmd_t)-1:0];
		mcu_cmd <= cur_cmd;
	endtask

	task automatic wait_strobe();
		do
			@(posedge clk);
		while (!(spi_cmd.rd || spi_cmd.wr));
	endtask

	task automatic serve_and_check(input int n);
		int m;
		int port;
		while (succ_port_q.size() < n)
			@(posedge clk);
		repeat (IDLE_TAIL) @(posedge clk);
		check_value("strobe count", n, served_cmd_q.size());
		check_value("success count", n, succ_port_q.size());
		m = (served_cmd_q.size() < succ_port_q.size()) ? served_cmd_q.size() : succ_port_q.size();
		if (m > n)
			m = n;
		for (int i = 0; i < m; i++)
		begin
			port = expected_port(exp_id_q[i]);
			check_value("o_spi_cmd", exp_cmd_q[i], served_cmd_q[i]);
			check_value("success port", port, succ_port_q[i]);
			check_value(data_name[port], served_byte_q[i], succ_data_q[i]);
			model_data[port] = served_byte_q[i];
		end
		check_value("o_data_mcu", model_data[0], data_mcu);
		check_value("o_data_fpga0", model_data[1], data_fpga0);
		check_value("o_data_fpga1", model_data[2], data_fpga1);
		exp_id_q.delete();
		exp_cmd_q.delete();
		served_cmd_q.delete();
		served_byte_q.delete();
		succ_port_q.delete();
		succ_data_q.delete();
	endtask

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// spi driver model, one transfer per strobe
	initial
	begin : spi_driver
		spi_cmd_t          cmd;
		int                wait_cycles;
		logic [DATA_W-1:0] byte_val;
		forever
		begin
			@(posedge clk);
			if (spi_cmd.rd || spi_cmd.wr)
			begin
				cmd         = spi_cmd;
				wait_cycles = 3 + ({$random(seed)} % 18);
				byte_val    = $random(seed);
				served_cmd_q.push_back(cmd);
				served_byte_q.push_back(byte_val);
				repeat (wait_cycles) @(posedge clk);
				spi_done  <= 1'b1;
				spi_rdata <= byte_val;
				repeat (2) @(posedge clk);
				spi_done <= 1'b0;
				$display("driver: %s addr %h mod %h data %h chip %h -> byte %h",
				         cmd.wr ? "wr" : "rd", cmd.addr, cmd.mod_sel, cmd.wr_data,
				         cmd.chip, byte_val);
			end
		end
	end

	always @(posedge clk)
	begin
		if (success_mcu)
		begin
			succ_port_q.push_back(0);
			succ_data_q.push_back(data_mcu);
		end
		if (success_fpga0)
		begin
			succ_port_q.push_back(1);
			succ_data_q.push_back(data_fpga0);
		end
		if (success_fpga1)
		begin
			succ_port_q.push_back(2);
			succ_data_q.push_back(data_fpga1);
		end
	end

	initial
	begin
		#((N_TRANS * 40 + 200) * CLK_PERIOD);
		$display("watchdog: the run did not finish in time, test %s stuck", test_name);
		$display("=== FAIL ===");
		$finish;
	end

	initial
	begin : main
		rd_en_mcu   = 1'b0;
		wr_en_mcu   = 1'b0;
		rd_en_fpga0 = 1'b0;
		rd_en_fpga1 = 1'b0;
		mcu_cmd     = '0;
		cur_cmd     = '0;
		spi_done    = 1'b0;
		spi_rdata   = '0;
		errors      = 0;
		checks      = 0;
		tests       = 0;
		foreach (model_data[i])
			model_data[i] = '0;
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		begin_test("reset values");
		repeat (8)
		begin
			@(posedge clk);
			check_value("o_spi_cmd.rd", 0, spi_cmd.rd);
			check_value("o_spi_cmd.wr", 0, spi_cmd.wr);
			check_value("o_success_mcu", 0, success_mcu);
			check_value("o_success_fpga0", 0, success_fpga0);
			check_value("o_success_fpga1", 0, success_fpga1);
			check_value("o_data_mcu", 0, data_mcu);
			check_value("o_data_fpga0", 0, data_fpga0);
			check_value("o_data_fpga1", 0, data_fpga1);
		end
		check_value("fsm state", ST_IDLE, dut_i.fsm_i.state);
		end_test();

		begin_test("mcu write and read");
		new_cmd();
		raise_req(REQ_MCU_WR);
		serve_and_check(1);
		drop_reqs();
		new_cmd();
		raise_req(REQ_MCU_RD);
		serve_and_check(1);
		drop_reqs();
		end_test();

		begin_test("fpga status reads");
		new_cmd();
		raise_req(REQ_FPGA_RD0);
		serve_and_check(1);
		drop_reqs();
		new_cmd();
		raise_req(REQ_FPGA_RD1);
		serve_and_check(1);
		drop_reqs();
		end_test();

		begin_test("oldest first and tie order");
		new_cmd();
		raise_req(REQ_MCU_WR);
		wait_strobe();
		raise_req(REQ_FPGA_RD1);	// arrival order runs against the tie order
		repeat (2) @(posedge clk);
		raise_req(REQ_FPGA_RD0);
		repeat (2) @(posedge clk);
		raise_req(REQ_MCU_RD);
		serve_and_check(4);
		drop_reqs();
		new_cmd();
		raise_req(REQ_MCU_RD);
		raise_req(REQ_MCU_WR);
		raise_req(REQ_FPGA_RD0);
		raise_req(REQ_FPGA_RD1);
		serve_and_check(4);
		drop_reqs();
		end_test();

		begin_test("repeated edge merges");
		new_cmd();
		raise_req(REQ_MCU_WR);
		wait_strobe();
		raise_req(REQ_FPGA_RD0);
		@(posedge clk);
		set_req(REQ_FPGA_RD0, 1'b0);
		@(posedge clk);
		set_req(REQ_FPGA_RD0, 1'b1);	// second edge while still pending
		serve_and_check(2);
		drop_reqs();
		end_test();

		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
		         tests, checks, errors, dut_i.assert_i.fail_cnt);
		if (total_errors() == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
spi_arb_pkg.sv
spi_bus_pkg.sv
req_tracker.sv
age_compare.sv
arb_fsm.sv
spi_cmd_mux.sv
return_router.sv
spi_arbiter.sv
spi_arbiter_assert.sv
tb_spi_arbiter.sv
